// ==== core_link.f ====
verilog/core_word_pkg.sv
verilog/flit_pkg.sv
verilog/core_channel.sv
verilog/flit_serializer.sv
verilog/flit_fifo.sv
verilog/flit_deserializer.sv
verilog/core_link_top.sv
tb/tb_core_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the core link testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f core_link.f \
	--top-module tb_core_link -Mdir obj_dir \
	&& ./obj_dir/Vtb_core_link | tee sim.log
grep -qx "Done: no errors" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== tb/tb_core_link.sv ====
// directed tests for the core link, words in at the core port and out of the deserializer
module tb_core_link
	import core_word_pkg::*, flit_pkg::*;
();

	localparam int ack_timeout = 200;    // cycles
	localparam int drain_timeout = 300;
	// header plus d1 of the first word, then one d1 every 3 flits until the FIFO fills
	localparam int stall_acks = (fifo_depth - 2) / 3 + 1;

	logic clk;
	logic reset;
	logic core_valid;
	route_t core_route;
	code_t core_code;
	cdata_t core_data;
	logic core_ack;
	logic rx_enable;
	logic word_valid;
	logic word_first;
	route_t word_route;
	payload_t word_payload;

	string cur_test;
	route_t exp_route [$];      // expected words, send order
	payload_t exp_payload [$];
	logic exp_first [$];
	int ack_count = 0;          // acks seen since time 0

	core_link_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// compare tasks
	////////////////////
	task automatic stop_run();
		$display("Done: errors found");
		$fatal(1, "first error, run stopped");
	endtask

	task automatic fail_stop(input string what);
		$display("%s (test %s)", what, cur_test);
		stop_run();
	endtask

	task automatic check_route(input route_t exp, input route_t act);
		if (exp !== act) begin
			$display("ERR %s word_route: expected %h, actual %h", cur_test, exp, act);
			stop_run();
		end
	endtask

	task automatic check_payload(input payload_t exp, input payload_t act);
		if (exp !== act) begin
			$display("ERR %s word_payload: expected %h, actual %h", cur_test, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
			stop_run();
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (exp != act) begin
			$display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			stop_run();
		end
	endtask

	// outputs settle by the falling edge
	always @(negedge clk) begin
		if (!reset && core_ack) begin
			ack_count++; // word taken on the next rising edge
		end
		if (!reset && word_valid) begin
			if (exp_route.size() == 0) begin
				fail_stop("word_valid came with no word outstanding");
			end else begin
				check_route(exp_route.pop_front(), word_route);
				check_payload(exp_payload.pop_front(), word_payload);
				check_flag("word_first", exp_first.pop_front(), word_first);
			end
		end
	end

	////////////////////
	// core side drivers
	////////////////////
	// called on a rising edge, returns on the edge that took the word
	task automatic send_word(input route_t route, input code_t code, input cdata_t data,
			input logic first);
		int waited;
		core_valid <= 1'b1;
		core_route <= route;
		core_code <= code;
		core_data <= data;
		exp_route.push_back(route);
		exp_payload.push_back({code[5:0], data}); // upper code bits never travel
		exp_first.push_back(first);
		waited = 0;
		@(negedge clk);
		while (!core_ack && waited < ack_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (!core_ack) begin
			fail_stop("core_ack never came for a held word");
		end else begin
			@(posedge clk);
		end
	endtask

	task automatic end_burst();
		core_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_route.size() != 0 && waited < drain_timeout) begin
			@(posedge clk);
			waited++;
		end
		if (exp_route.size() != 0) begin
			fail_stop("timed out waiting for word_valid");
		end else begin
			@(posedge clk);
		end
	endtask

	task automatic wait_acks(input int target);
		int waited;
		waited = 0;
		while (ack_count < target && waited < ack_timeout) begin
			@(posedge clk);
			waited++;
		end
		if (ack_count < target) begin
			fail_stop("timed out waiting for acks before the stall");
		end
	endtask

	////////////////////
	// tests
	////////////////////
	task automatic test_reset();
		cur_test = "reset";
		repeat (10) begin
			@(negedge clk);
			check_flag("core_ack", 1'b0, core_ack);
			check_flag("word_valid", 1'b0, word_valid);
		end
		@(posedge clk);
		reset <= 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_flag("core_ack", 1'b0, core_ack); // nothing offered yet
			check_flag("word_valid", 1'b0, word_valid);
		end
		@(posedge clk);
	endtask

	task automatic test_single();
		cur_test = "single word";
		send_word(route_t'($urandom()), code_t'($urandom()), cdata_t'($urandom()), 1'b1);
		end_burst();
		wait_drain();
	endtask

	task automatic test_burst();
		route_t r;
		cur_test = "same-route burst";
		r = route_t'($urandom());
		for (int i = 0; i < 5; i++) begin
			send_word(r, code_t'($urandom()), cdata_t'($urandom()), i == 0); // one header
		end
		end_burst();
		wait_drain();
	endtask

	task automatic test_route_change();
		route_t ra;
		route_t rb;
		route_t r;
		route_t prev;
		logic [6:0] pick;
		cur_test = "route change";
		ra = route_t'($urandom());
		rb = ~ra;           // always differs
		pick = 7'b0101100;  // A A B B A B A
		prev = ra;
		for (int i = 0; i < 7; i++) begin
			r = pick[i] ? rb : ra;
			send_word(r, code_t'($urandom()), cdata_t'($urandom()), i == 0 || r != prev);
			prev = r;
		end
		end_burst();
		wait_drain();
	endtask

	task automatic test_backpressure();
		route_t r;
		int base;
		cur_test = "back-pressure";
		r = route_t'($urandom());
		base = ack_count;
		rx_enable <= 1'b0;
		fork
			begin
				for (int i = 0; i < 6; i++) begin
					send_word(r, code_t'($urandom()), cdata_t'($urandom()), i == 0);
				end
				end_burst();
			end
			begin
				wait_acks(base + stall_acks);
				repeat (20) @(posedge clk); // FIFO full, ack must stay low
				check_count("acks before stall", stall_acks, ack_count - base);
				rx_enable <= 1'b1;
			end
		join
		wait_drain();
	endtask

	initial begin
		void'($urandom(24603));
		reset = 1'b1;
		core_valid = 1'b0;
		core_route = '0;
		core_code = '0;
		core_data = '0;
		rx_enable = 1'b1;
		cur_test = "setup";
		test_reset();
		test_single();
		test_burst();
		test_route_change();
		test_backpressure();
		if (exp_route.size() == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			fail_stop("words still outstanding at the end");
		end
	end

endmodule

// ==== verilog/core_channel.sv ====
// word channel from the core, valid held until ack
interface core_channel
	import core_word_pkg::*;
();

	route_t route;  // destination
	code_t code;
	cdata_t data;
	logic valid;    // word present
	logic ack;      // word taken, next may follow in the same cycle

	// word source
	modport core (
		output route, code, data, valid,
		input ack
	);

	// flit side
	modport serializer (
		input route, code, data, valid,
		output ack
	);

endinterface

// ==== verilog/core_link_top.sv ====
// core word in, rebuilt word out through serializer, FIFO and deserializer
module core_link_top
	import core_word_pkg::*, flit_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic core_valid,
	input route_t core_route,
	input code_t core_code,
	input cdata_t core_data,
	output logic core_ack,
	input logic rx_enable,
	output logic word_valid,
	output logic word_first,
	output route_t word_route,
	output payload_t word_payload
);

	core_channel ch ();

	flit_t ser_flit;      // serializer to FIFO
	logic ser_wrreq;
	logic fifo_full;
	flit_t fifo_q;        // FIFO to deserializer
	logic fifo_empty;
	logic des_rdreq;

	// core side of the channel
	assign ch.route = core_route;
	assign ch.code = core_code;
	assign ch.data = core_data;
	assign ch.valid = core_valid;
	assign core_ack = ch.ack;

	flit_serializer i_ser (
		.clk(clk),
		.reset(reset),
		.ch(ch.serializer),
		.full(fifo_full),
		.flit(ser_flit),
		.wrreq(ser_wrreq)
	);

	flit_fifo i_fifo (
		.clk(clk),
		.reset(reset),
		.flit(ser_flit),
		.wrreq(ser_wrreq),
		.full(fifo_full),
		.rdreq(des_rdreq),
		.q(fifo_q),
		.empty(fifo_empty)
	);

	flit_deserializer i_des (
		.clk(clk),
		.reset(reset),
		.q(fifo_q),
		.empty(fifo_empty),
		.rdreq(des_rdreq),
		.rx_enable(rx_enable),
		.word_valid(word_valid),
		.word_first(word_first),
		.word_route(word_route),
		.word_payload(word_payload)
	);

endmodule

// ==== verilog/core_word_pkg.sv ====
////////////////////
// core output word
//
//    10      8      24
// [ route | code | data ]
//
// only the low 30 bits travel as payload
////////////////////

package core_word_pkg;

	localparam int route_w = 10;   // destination field
	localparam int code_w = 8;
	localparam int cdata_w = 24;
	localparam int payload_w = 30; // low 6 code bits plus data

	// destination of a word
	typedef logic [route_w-1:0] route_t;

	typedef logic [code_w-1:0] code_t;
	typedef logic [cdata_w-1:0] cdata_t;

	// {code[5:0], data}
	typedef logic [payload_w-1:0] payload_t;

endpackage

// ==== verilog/flit_deserializer.sv ====
// rebuilds route and payload from the flit stream
module flit_deserializer
	import core_word_pkg::*, flit_pkg::*;
(
	input logic clk,
	input logic reset,
	input flit_t q,
	input logic empty,
	output logic rdreq,
	input logic rx_enable,
	output logic word_valid,
	output logic word_first,
	output route_t word_route,
	output payload_t word_payload
);

	des_state_t state;          // position of the flit now in q
	logic pend;                 // q holds a flit popped last cycle
	logic first_q;              // current word came right after a header
	route_t route_q;            // route from the last header
	logic [flit_w-2:0] part1;   // payload[29:20]
	logic [flit_w-2:0] part2;   // payload[19:10]

	assign rdreq = !empty && rx_enable;

	// word completes as the d3 flit shows up in q
	assign word_valid = pend && state == des_d3;
	assign word_first = first_q;
	assign word_route = route_q;
	assign word_payload = {part1, part2, q[flit_w-2:0]};

	////////////////////
	// flit position
	////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= des_head;
			pend <= 1'b0;
			first_q <= 1'b0;
		end else begin
			pend <= rdreq;
			if (pend) begin
				case (state)
					des_head: begin
						state <= des_d1;
						first_q <= 1'b1;
					end
					des_d1: state <= des_d2;
					des_d2: state <= des_d3;
					des_d3: begin
						// tail closes the run, otherwise data of the next word follows
						state <= q[flit_w-1] ? des_head : des_d1;
						first_q <= 1'b0;
					end
					default: state <= des_head;
				endcase
			end
		end
	end

	// field capture
	always_ff @(posedge clk) begin
		if (pend) begin
			case (state)
				des_head: route_q <= q[flit_w-2:0];
				des_d1: part1 <= q[flit_w-2:0];
				des_d2: part2 <= q[flit_w-2:0];
				default: ; // d3 goes straight out
			endcase
		end
	end

	// serializer only tails data flits
	a_head_no_tail: assert property (@(posedge clk) disable iff (reset)
		pend && state == des_head |-> !q[flit_w-1]);

endmodule

// ==== verilog/flit_fifo.sv ====
// circular flit buffer between serializer and deserializer
module flit_fifo
	import flit_pkg::*;
(
	input logic clk,
	input logic reset,
	input flit_t flit,
	input logic wrreq,
	output logic full,
	input logic rdreq,
	output flit_t q,
	output logic empty
);

	flit_t mem [fifo_depth];
	logic [fifo_addr_w-1:0] wr_ptr;  // wraps naturally at depth 8
	logic [fifo_addr_w-1:0] rd_ptr;
	logic [fifo_addr_w:0] count;     // 0 to fifo_depth
	logic wr_en;
	logic rd_en;

	assign full = count == (fifo_addr_w + 1)'(fifo_depth);
	assign empty = count == '0;
	assign wr_en = wrreq && !full;
	assign rd_en = rdreq && !empty;

	////////////////////
	// pointers and count
	////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// storage and registered read port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= flit;
		end
		if (rd_en) begin
			q <= mem[rd_ptr]; // valid the cycle after rdreq
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		wrreq |-> !full);

	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		rdreq |-> !empty);

endmodule

// ==== verilog/flit_pkg.sv ====
////////////////////
// router flit format
//
//    1       10
// [ tail | route or data ]
//
// header flit carries the route, three data flits carry the payload
////////////////////

package flit_pkg;

	localparam int flit_w = 11;     // tail bit on top
	localparam int fifo_depth = 8;  // flits
	localparam int fifo_addr_w = 3;

	typedef logic [flit_w-1:0] flit_t;

	// serializer position, idle waits for a word
	typedef enum logic [2:0] {
		ser_idle,
		ser_head,
		ser_d1,
		ser_d2,
		ser_d3
	} ser_state_t;

	// deserializer expects this flit next in q
	typedef enum logic [1:0] {
		des_head,
		des_d1,
		des_d2,
		des_d3
	} des_state_t;

endpackage

// ==== verilog/flit_serializer.sv ====
// splits core words into header and data flits
// consecutive words on one route share a header
module flit_serializer
	import core_word_pkg::*, flit_pkg::*;
(
	input logic clk,
	input logic reset,
	core_channel.serializer ch,
	input logic full,
	output flit_t flit,
	output logic wrreq
);

	ser_state_t state;
	ser_state_t state_nxt;
	route_t route_q;      // route of the word being sent
	payload_t payload_q;  // its 30 carried bits
	logic last_tail;      // last d3 flit closed the run
	logic same_route;
	logic tail_now;       // tail bit for the d3 flit
	logic latch;

	assign same_route = ch.route == route_q;
	// run continues only if the next word is already waiting
	assign tail_now = !(ch.valid && same_route);
	assign latch = ch.valid && !full && (state == ser_idle || state == ser_d3);

	////////////////////
	// next state
	////////////////////
	always_comb begin
		state_nxt = state;
		if (!full) begin // stall holds everything
			case (state)
				ser_idle: begin
					if (ch.valid) begin
						state_nxt = (same_route && !last_tail) ? ser_d1 : ser_head;
					end
				end
				ser_head: state_nxt = ser_d1;
				ser_d1: state_nxt = ser_d2;
				ser_d2: state_nxt = ser_d3;
				ser_d3: begin
					if (ch.valid) begin
						state_nxt = same_route ? ser_d1 : ser_head; // skip header
					end else begin
						state_nxt = ser_idle;
					end
				end
				default: state_nxt = ser_idle;
			endcase
		end
	end

	////////////////////
	// flit mux
	////////////////////
	always_comb begin
		case (state)
			ser_head: flit = {1'b0, route_q};             // header never tails
			ser_d1: flit = {1'b0, payload_q[29:20]};      // first part highest
			ser_d2: flit = {1'b0, payload_q[19:10]};
			ser_d3: flit = {tail_now, payload_q[9:0]};
			default: flit = '0;
		endcase
	end

	assign wrreq = state != ser_idle && !full;
	assign ch.ack = state == ser_d1 && !full; // word consumed with its first data flit

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ser_idle;
			last_tail <= 1'b1; // first word always gets a header
		end else begin
			state <= state_nxt;
			if (wrreq && state == ser_d3) begin
				last_tail <= tail_now;
			end
		end
	end

	// word registers
	always_ff @(posedge clk) begin
		if (latch) begin
			route_q <= ch.route;
			payload_q <= {ch.code[5:0], ch.data}; // upper code bits dropped
		end
	end

	// FIFO never sees a write it would lose
	a_no_wr_full: assert property (@(posedge clk) disable iff (reset)
		wrreq |-> !full);

	// ack only on the d1 write, for the word still held by the core
	a_ack_d1: assert property (@(posedge clk) disable iff (reset)
		ch.ack |-> state == ser_d1 && ch.valid && ch.route == route_q
			&& payload_q == {ch.code[5:0], ch.data});

endmodule
